// ==== src/core_pkg.sv ====
package core_pkg;

    typedef logic [31:0] word_t;
    typedef logic [3:0]  reg_addr_t;  // rv32e, 16 registers
    typedef logic [3:0]  alu_op_t;
    typedef logic [1:0]  mem_size_t;

    localparam alu_op_t alu_add    = 4'd0;
    localparam alu_op_t alu_sub    = 4'd1;
    localparam alu_op_t alu_sll    = 4'd2;
    localparam alu_op_t alu_slt    = 4'd3;
    localparam alu_op_t alu_sltu   = 4'd4;
    localparam alu_op_t alu_xor    = 4'd5;
    localparam alu_op_t alu_srl    = 4'd6;
    localparam alu_op_t alu_sra    = 4'd7;
    localparam alu_op_t alu_or     = 4'd8;
    localparam alu_op_t alu_and    = 4'd9;
    localparam alu_op_t alu_pass_b = 4'd10;

    // matches funct3[1:0] of loads and stores
    localparam mem_size_t size_byte = 2'd0;
    localparam mem_size_t size_half = 2'd1;
    localparam mem_size_t size_word = 2'd2;

    localparam logic [6:0] opc_lui    = 7'b0110111;
    localparam logic [6:0] opc_auipc  = 7'b0010111;
    localparam logic [6:0] opc_jal    = 7'b1101111;
    localparam logic [6:0] opc_jalr   = 7'b1100111;
    localparam logic [6:0] opc_branch = 7'b1100011;
    localparam logic [6:0] opc_load   = 7'b0000011;
    localparam logic [6:0] opc_store  = 7'b0100011;
    localparam logic [6:0] opc_op_imm = 7'b0010011;
    localparam logic [6:0] opc_op     = 7'b0110011;
    localparam logic [6:0] opc_system = 7'b1110011;

    localparam word_t reset_pc = 32'h0000_0000;

endpackage

// ==== src/fetch_unit.sv ====
`timescale 1ns/1ps

module fetch_unit (
    input  logic            clock,
    input  logic            rst,
    input  logic            start,
    input  core_pkg::word_t pc,
    output logic            req,
    output core_pkg::word_t addr,
    input  logic            done,
    input  core_pkg::word_t rdata,
    output core_pkg::word_t inst
);

    assign addr = pc;  // pc is held by core_top until the word returns

    always_ff @(posedge clock) begin
        if (rst) begin
            req <= 1'b0;
        end else if (start) begin
            req <= 1'b1;
        end else if (done) begin
            req <= 1'b0;
        end
    end

    // instruction word stays valid through exec and mem
    always_ff @(posedge clock) begin
        if (done) begin
            inst <= rdata;
        end
    end

    // a misaligned jump target would land here
    pc_aligned: assert property (
        @(posedge clock) disable iff (rst)
        (start || req) |-> pc[1:0] == 2'b00
    ) else $error("fetch from misaligned pc %h", pc);

endmodule

// ==== src/decoder.sv ====
`timescale 1ns/1ps

module decoder (
    input  core_pkg::word_t     inst,
    output core_pkg::reg_addr_t rs1,
    output core_pkg::reg_addr_t rs2,
    output core_pkg::reg_addr_t rd,
    output core_pkg::word_t     imm,
    output core_pkg::alu_op_t   alu_op,
    output logic                use_imm,
    output logic                reg_write,
    output logic                is_load,
    output logic                is_store,
    output logic                is_branch,
    output logic                is_jal,
    output logic                is_jalr,
    output logic                is_lui,
    output logic                is_auipc,
    output logic                is_ebreak,
    output core_pkg::mem_size_t mem_size,
    output logic                mem_unsigned,
    output logic                bad
);
    import core_pkg::*;

    logic [6:0] opcode;
    logic [2:0] f3;
    logic [6:0] f7;
    logic       alt;
    logic       uses_rs1, uses_rs2, uses_rd;
    logic       enc_bad;
    word_t      i_imm, s_imm, b_imm, u_imm, j_imm;
    alu_op_t    arith_op;

    assign opcode = inst[6:0];
    assign f3     = inst[14:12];
    assign f7     = inst[31:25];

    assign rs1 = inst[18:15];
    assign rs2 = inst[23:20];
    assign rd  = inst[10:7];

    assign mem_size     = f3[1:0];
    assign mem_unsigned = f3[2];

    assign i_imm = {{20{inst[31]}}, inst[31:20]};
    assign s_imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    assign b_imm = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign u_imm = {inst[31:12], 12'b0};
    assign j_imm = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

    // bit 30 means sub only for reg-reg, but sra for both forms
    assign alt = f7[5] && (opcode == opc_op || f3 == 3'b101);

    always_comb begin
        case (f3)
            3'b000:  arith_op = alt ? alu_sub : alu_add;
            3'b001:  arith_op = alu_sll;
            3'b010:  arith_op = alu_slt;
            3'b011:  arith_op = alu_sltu;
            3'b100:  arith_op = alu_xor;
            3'b101:  arith_op = alt ? alu_sra : alu_srl;
            3'b110:  arith_op = alu_or;
            default: arith_op = alu_and;
        endcase
    end

    always_comb begin
        imm = i_imm;
        alu_op = alu_pass_b;
        {use_imm, reg_write, is_load, is_store, is_branch} = '0;
        {is_jal, is_jalr, is_lui, is_auipc, is_ebreak} = '0;
        {uses_rs1, uses_rs2, uses_rd} = '0;
        enc_bad = 1'b0;
        case (opcode)
            opc_lui, opc_auipc: begin
                imm = u_imm;
                alu_op = alu_add;
                is_lui = (opcode == opc_lui);
                is_auipc = (opcode == opc_auipc);
                {use_imm, reg_write, uses_rd} = 3'b111;
            end
            opc_jal: begin
                imm = j_imm;
                {is_jal, reg_write, uses_rd} = 3'b111;
            end
            opc_jalr: begin
                alu_op = alu_add;
                {is_jalr, use_imm, reg_write, uses_rs1, uses_rd} = 5'b11111;
                enc_bad = (f3 != 3'b000);
            end
            opc_branch: begin
                imm = b_imm;
                {is_branch, uses_rs1, uses_rs2} = 3'b111;
                enc_bad = (f3[2:1] == 2'b01);
            end
            opc_load: begin
                alu_op = alu_add;
                {is_load, use_imm, reg_write, uses_rs1, uses_rd} = 5'b11111;
                enc_bad = (f3 == 3'b011) || (f3[2:1] == 2'b11);  // no lwu, no ld
            end
            opc_store: begin
                imm = s_imm;
                alu_op = alu_add;
                {is_store, use_imm, uses_rs1, uses_rs2} = 4'b1111;
                enc_bad = f3[2] || (f3[1:0] == 2'b11);
            end
            opc_op_imm: begin
                alu_op = arith_op;
                {use_imm, reg_write, uses_rs1, uses_rd} = 4'b1111;
                if (f3 == 3'b001) begin
                    enc_bad = (f7 != 7'b0);
                end else if (f3 == 3'b101) begin
                    enc_bad = (f7 != 7'b0) && (f7 != 7'b0100000);
                end
            end
            opc_op: begin
                alu_op = arith_op;
                {reg_write, uses_rs1, uses_rs2, uses_rd} = 4'b1111;
                enc_bad = (f7 != 7'b0) &&
                          !(f7 == 7'b0100000 && (f3 == 3'b000 || f3 == 3'b101));
            end
            opc_system: begin
                is_ebreak = (inst == 32'h0010_0073);
                enc_bad = !is_ebreak;  // ecall, csr ops not supported
            end
            default: enc_bad = 1'b1;
        endcase
    end

    // x16..x31 do not exist on rv32e
    assign bad = enc_bad || (uses_rs1 && inst[19]) || (uses_rs2 && inst[24])
                 || (uses_rd && inst[11]);

endmodule

// ==== src/reg_file.sv ====
`timescale 1ns/1ps

module reg_file (
    input  logic                clock,
    input  logic                we,
    input  core_pkg::reg_addr_t waddr,
    input  core_pkg::reg_addr_t raddr1,
    input  core_pkg::reg_addr_t raddr2,
    input  core_pkg::word_t     wdata,
    output core_pkg::word_t     rdata1,
    output core_pkg::word_t     rdata2
);

    core_pkg::word_t regs [16];

    always_ff @(posedge clock) begin
        if (we && waddr != 4'd0) begin
            regs[waddr] <= wdata;
        end
    end

    assign rdata1 = (raddr1 == 4'd0) ? 32'h0 : regs[raddr1];
    assign rdata2 = (raddr2 == 4'd0) ? 32'h0 : regs[raddr2];

endmodule

// ==== src/execute_unit.sv ====
`timescale 1ns/1ps

module execute_unit (
    input  core_pkg::word_t   pc,
    input  core_pkg::word_t   rs1_value,
    input  core_pkg::word_t   rs2_value,
    input  core_pkg::word_t   imm,
    input  core_pkg::alu_op_t alu_op,
    input  logic              use_imm,
    input  logic              is_branch,
    input  logic              is_jal,
    input  logic              is_jalr,
    input  logic              is_lui,
    input  logic              is_auipc,
    input  logic [2:0]        funct3,
    output core_pkg::word_t   result,
    output core_pkg::word_t   next_pc,
    output core_pkg::word_t   link_value
);
    import core_pkg::*;

    word_t op_a, op_b, jalr_target;
    logic  cond, taken;

    // lui adds its immediate to zero, auipc to the pc
    assign op_a = is_auipc ? pc : (is_lui ? 32'h0 : rs1_value);
    assign op_b = use_imm ? imm : rs2_value;

    always_comb begin
        case (alu_op)
            alu_add:  result = op_a + op_b;
            alu_sub:  result = op_a - op_b;
            alu_sll:  result = op_a << op_b[4:0];
            alu_slt:  result = {31'b0, $signed(op_a) < $signed(op_b)};
            alu_sltu: result = {31'b0, op_a < op_b};
            alu_xor:  result = op_a ^ op_b;
            alu_srl:  result = op_a >> op_b[4:0];
            alu_sra:  result = $unsigned($signed(op_a) >>> op_b[4:0]);
            alu_or:   result = op_a | op_b;
            alu_and:  result = op_a & op_b;
            default:  result = op_b;
        endcase
    end

    always_comb begin
        case (funct3)
            3'b000:  cond = (rs1_value == rs2_value);
            3'b001:  cond = (rs1_value != rs2_value);
            3'b100:  cond = ($signed(rs1_value) < $signed(rs2_value));
            3'b101:  cond = ($signed(rs1_value) >= $signed(rs2_value));
            3'b110:  cond = (rs1_value < rs2_value);
            default: cond = (rs1_value >= rs2_value);
        endcase
    end

    assign taken       = is_branch && cond;
    assign link_value  = pc + 32'd4;
    assign jalr_target = (rs1_value + imm) & ~32'd1;

    assign next_pc = is_jalr ? jalr_target :
                     (is_jal || taken) ? pc + imm : link_value;

endmodule

// ==== src/load_store_unit.sv ====
`timescale 1ns/1ps

module load_store_unit (
    input  logic                clock,
    input  logic                rst,
    input  logic                start,
    input  logic                is_store,
    input  logic                mem_unsigned,
    input  core_pkg::mem_size_t size,
    input  core_pkg::word_t     addr,
    input  core_pkg::word_t     store_value,
    output logic                req,
    output logic                write,
    output core_pkg::word_t     bus_addr,
    output core_pkg::word_t     bus_wdata,
    output logic [3:0]          strb,
    input  logic                done,
    input  core_pkg::word_t     rdata,
    output core_pkg::word_t     load_value
);
    import core_pkg::*;

    logic [1:0] offset_q;
    mem_size_t  size_q;
    logic       unsigned_q;
    logic [3:0] base_strb;
    word_t      lane, extended;

    always_comb begin
        case (size)
            size_byte: base_strb = 4'b0001;
            size_half: base_strb = 4'b0011;
            default:   base_strb = 4'b1111;
        endcase
    end

    always_ff @(posedge clock) begin
        if (rst) begin
            req <= 1'b0;
        end else if (start) begin
            req <= 1'b1;
        end else if (done) begin
            req <= 1'b0;
        end
    end

    // request payload, held while req waits for done
    always_ff @(posedge clock) begin
        if (start) begin
            write      <= is_store;
            bus_addr   <= {addr[31:2], 2'b00};
            bus_wdata  <= store_value << {addr[1:0], 3'b000};
            strb       <= base_strb << addr[1:0];
            offset_q   <= addr[1:0];
            size_q     <= size;
            unsigned_q <= mem_unsigned;
        end
    end

    assign lane = rdata >> {offset_q, 3'b000};  // wanted bytes down to lane 0

    always_comb begin
        case (size_q)
            size_byte: extended = {{24{!unsigned_q && lane[7]}}, lane[7:0]};
            size_half: extended = {{16{!unsigned_q && lane[15]}}, lane[15:0]};
            default:   extended = lane;
        endcase
    end

    always_ff @(posedge clock) begin
        if (done && !write) begin
            load_value <= extended;
        end
    end

    access_aligned: assert property (
        @(posedge clock) disable iff (rst)
        start |-> (size != size_half || !addr[0]) &&
                  (size != size_word || addr[1:0] == 2'b00)
    ) else $error("misaligned access at %h", addr);

endmodule

// ==== src/core_top.sv ====
`timescale 1ns/1ps

module core_top (
    input  logic            clock,
    input  logic            rst,
    output logic            mem_valid,
    output logic            mem_write,
    output core_pkg::word_t mem_addr,
    output core_pkg::word_t mem_wdata,
    output logic [3:0]      mem_strb,
    input  logic            mem_ready,
    input  core_pkg::word_t mem_rdata,
    output logic            retire,
    output core_pkg::word_t retire_pc,
    output core_pkg::word_t retire_rd_value,
    output logic            halt,
    output logic            illegal
);
    import core_pkg::*;

    typedef enum logic [1:0] {st_fetch, st_exec, st_mem, st_stop} core_state_t;

    core_state_t state;
    word_t       pc, f_addr, f_inst, imm, rs1_value, rs2_value;
    word_t       result, next_pc, link_value, wb_value, rf_wdata;
    word_t       l_bus_addr, l_wdata, load_value, ret_value_q;
    reg_addr_t   rs1, rs2, rd;
    alu_op_t     alu_op;
    mem_size_t   mem_size;
    logic [3:0]  l_strb;
    logic        use_imm, reg_write, is_load, is_store, is_branch, is_jal, is_jalr;
    logic        is_lui, is_auipc, is_ebreak, mem_unsigned, bad;
    logic        f_req, f_start, f_done, l_req, l_write, l_start, l_done;
    logic        fetch_grant, exec_retire, load_wb, rf_we;

    fetch_unit u_fetch (
        .clock(clock), .rst(rst), .start(f_start), .pc(pc), .req(f_req), .addr(f_addr),
        .done(f_done), .rdata(mem_rdata), .inst(f_inst)
    );

    decoder u_dec (
        .inst(f_inst), .rs1(rs1), .rs2(rs2), .rd(rd), .imm(imm), .alu_op(alu_op),
        .use_imm(use_imm), .reg_write(reg_write), .is_load(is_load), .is_store(is_store),
        .is_branch(is_branch), .is_jal(is_jal), .is_jalr(is_jalr), .is_lui(is_lui),
        .is_auipc(is_auipc), .is_ebreak(is_ebreak), .mem_size(mem_size),
        .mem_unsigned(mem_unsigned), .bad(bad)
    );

    reg_file u_rf (
        .clock(clock), .we(rf_we), .waddr(rd), .raddr1(rs1), .raddr2(rs2),
        .wdata(rf_wdata), .rdata1(rs1_value), .rdata2(rs2_value)
    );

    execute_unit u_exu (
        .pc(pc), .rs1_value(rs1_value), .rs2_value(rs2_value), .imm(imm), .alu_op(alu_op),
        .use_imm(use_imm), .is_branch(is_branch), .is_jal(is_jal), .is_jalr(is_jalr),
        .is_lui(is_lui), .is_auipc(is_auipc), .funct3(f_inst[14:12]), .result(result),
        .next_pc(next_pc), .link_value(link_value)
    );

    load_store_unit u_lsu (
        .clock(clock), .rst(rst), .start(l_start), .is_store(is_store),
        .mem_unsigned(mem_unsigned), .size(mem_size), .addr(result), .store_value(rs2_value),
        .req(l_req), .write(l_write), .bus_addr(l_bus_addr), .bus_wdata(l_wdata),
        .strb(l_strb), .done(l_done), .rdata(mem_rdata), .load_value(load_value)
    );

    // simple arbiter, the state says who owns the port
    assign fetch_grant = (state == st_fetch);
    assign mem_valid   = fetch_grant ? f_req : l_req;
    assign mem_write   = fetch_grant ? 1'b0 : l_write;
    assign mem_addr    = fetch_grant ? f_addr : l_bus_addr;
    assign mem_wdata   = fetch_grant ? 32'h0 : l_wdata;
    assign mem_strb    = fetch_grant ? 4'b1111 : l_strb;

    assign f_done  = fetch_grant && mem_valid && mem_ready;
    assign l_done  = (state == st_mem) && mem_valid && mem_ready;
    assign f_start = fetch_grant && !f_req;  // first cycle in st_fetch
    assign l_start = (state == st_exec) && !bad && (is_load || is_store);

    assign exec_retire = (state == st_exec) && !bad && !is_ebreak && !is_load && !is_store;

    assign wb_value = (is_jal || is_jalr) ? link_value : result;
    assign rf_we    = (exec_retire && reg_write) || load_wb;
    assign rf_wdata = load_wb ? load_value : wb_value;

    // load data lands one cycle after the transfer, rd still decoded from f_inst
    assign retire_rd_value = !load_wb ? ret_value_q :
                             (rd != 4'd0) ? load_value : 32'h0;

    always_ff @(posedge clock) begin
        if (rst) begin
            state   <= st_fetch;
            pc      <= reset_pc;
            retire  <= 1'b0;
            load_wb <= 1'b0;
            halt    <= 1'b0;
            illegal <= 1'b0;
        end else begin
            retire  <= 1'b0;
            load_wb <= 1'b0;
            case (state)
                st_fetch: if (f_done) state <= st_exec;
                st_exec: begin
                    if (bad) begin
                        illegal <= 1'b1;
                        state   <= st_stop;
                    end else if (is_ebreak) begin
                        halt  <= 1'b1;
                        state <= st_stop;
                    end else if (is_load || is_store) begin
                        state <= st_mem;
                    end else begin
                        pc     <= next_pc;
                        retire <= 1'b1;
                        state  <= st_fetch;
                    end
                end
                st_mem: begin
                    if (l_done) begin
                        pc      <= next_pc;
                        retire  <= 1'b1;
                        load_wb <= !is_store;
                        state   <= st_fetch;
                    end
                end
                default: state <= st_stop;  // stays stopped until reset
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (exec_retire || l_done) begin
            retire_pc   <= pc;
            ret_value_q <= (reg_write && rd != 4'd0) ? wb_value : 32'h0;
        end
    end

    mem_req_held: assert property (
        @(posedge clock) disable iff (rst)
        mem_valid && !mem_ready |=> mem_valid && $stable(mem_addr) && $stable(mem_write)
    ) else $error("memory request dropped or changed before ready");

endmodule

// ==== testbench/tb_core_top.sv ====
`timescale 1ns/1ps

module tb_core_top;
    import core_pkg::*;

    logic       clock = 1'b0;
    logic       rst = 1'b1;
    logic       mem_ready = 1'b0;
    word_t      mem_rdata = 32'h0;
    logic       mem_valid, mem_write, retire, halt, illegal;
    word_t      mem_addr, mem_wdata, retire_pc, retire_rd_value;
    logic [3:0] mem_strb;

    word_t      mem [256];
    word_t      prog [$];      // instruction words from reset_pc upward
    logic       ev_store [$];  // 0 retire, 1 store
    word_t      ev_addr [$];   // retire pc or store address
    word_t      ev_data [$];   // rd value or store data
    logic [3:0] ev_strb [$];

    logic [7:0] lfsr = 8'd91;
    logic       pending = 1'b0;
    int         delay_left = 0;

    core_top u_dut (
        .clock(clock), .rst(rst), .mem_valid(mem_valid), .mem_write(mem_write),
        .mem_addr(mem_addr), .mem_wdata(mem_wdata), .mem_strb(mem_strb),
        .mem_ready(mem_ready), .mem_rdata(mem_rdata), .retire(retire),
        .retire_pc(retire_pc), .retire_rd_value(retire_rd_value),
        .halt(halt), .illegal(illegal)
    );

    always #5 clock = ~clock;

    // x^8 + x^6 + x^5 + x^4 + 1
    function automatic logic [7:0] lfsr_step(input logic [7:0] s);
        return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
    endfunction

    task automatic draw_delay(output int d);
        d = 0;
        repeat (2) begin
            lfsr = lfsr_step(lfsr);
            d = {d[30:0], lfsr[0]};
        end
    endtask

    // memory model, ready after 0 to 3 cycles of valid
    always @(posedge clock) begin
        #1;
        if (rst || mem_ready) begin
            mem_ready = 1'b0;  // transfer done at this edge
            pending = 1'b0;
        end else if (mem_valid) begin
            if (!pending) begin
                pending = 1'b1;
                draw_delay(delay_left);
            end
            if (delay_left == 0) begin
                mem_rdata = mem[mem_addr[9:2]];
                mem_ready = 1'b1;
            end else begin
                delay_left = delay_left - 1;
            end
        end
    end

    function automatic word_t r_type(input logic [6:0] f7, input logic [2:0] f3,
                                     input int rd, input int rs1, input int rs2);
        return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], opc_op};
    endfunction

    function automatic word_t i_type(input logic [6:0] opc, input logic [2:0] f3,
                                     input int rd, input int rs1, input int imm);
        return {imm[11:0], rs1[4:0], f3, rd[4:0], opc};
    endfunction

    function automatic word_t s_type(input logic [2:0] f3, input int rs1, input int rs2,
                                     input int imm);
        return {imm[11:5], rs2[4:0], rs1[4:0], f3, imm[4:0], opc_store};
    endfunction

    function automatic word_t b_type(input logic [2:0] f3, input int rs1, input int rs2,
                                     input int imm);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3, imm[4:1], imm[11], opc_branch};
    endfunction

    function automatic word_t u_type(input logic [6:0] opc, input int rd, input int upper);
        return {upper[19:0], rd[4:0], opc};
    endfunction

    function automatic word_t j_type(input int rd, input int imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], opc_jal};
    endfunction

    function automatic word_t byte_mask(input logic [3:0] strb);
        return {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
    endfunction

    task automatic expect_retire(input word_t offset, input word_t value);
        ev_store.push_back(1'b0);
        ev_addr.push_back(reset_pc + offset);
        ev_data.push_back(value);
        ev_strb.push_back(4'b0000);
    endtask

    task automatic expect_store(input word_t addr, input word_t data, input logic [3:0] strb);
        ev_store.push_back(1'b1);
        ev_addr.push_back(addr);
        ev_data.push_back(data);
        ev_strb.push_back(strb);
    endtask

    task automatic stop_failed();
        $display("STATUS: FAIL");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic check_value(input string name, input word_t expected, input word_t actual);
        assert (actual === expected) else begin
            $display("MISMATCH at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
            stop_failed();
        end
    endtask

    task automatic check_true(input logic cond, input string what);
        assert (cond) else begin
            $display("ERROR at %0t ns: %s", $time, what);
            stop_failed();
        end
    endtask

    task automatic build_main_program();
        word_t wrong_path;
        wrong_path = i_type(opc_op_imm, 3'b000, 1, 0, 1);  // addi x1, x0, 1, never retires
        prog.push_back(u_type(opc_lui, 1, 'h12345));
        expect_retire(0, 32'h12345000);
        prog.push_back(i_type(opc_op_imm, 3'b000, 1, 1, 'h678));
        expect_retire(4, 32'h12345678);
        prog.push_back(u_type(opc_auipc, 2, 1));
        expect_retire(8, 32'h00001008);
        prog.push_back(i_type(opc_op_imm, 3'b000, 3, 0, -5));
        expect_retire(12, 32'hfffffffb);
        prog.push_back(i_type(opc_op_imm, 3'b010, 4, 3, 1));  // slti
        expect_retire(16, 32'h1);
        prog.push_back(i_type(opc_op_imm, 3'b011, 5, 3, 1));  // sltiu
        expect_retire(20, 32'h0);
        prog.push_back(i_type(opc_op_imm, 3'b100, 6, 1, -1));
        expect_retire(24, 32'hedcba987);
        prog.push_back(i_type(opc_op_imm, 3'b101, 7, 3, 'h401));
        expect_retire(28, 32'hfffffffd);
        prog.push_back(i_type(opc_op_imm, 3'b101, 8, 3, 28));
        expect_retire(32, 32'h0000000f);
        prog.push_back(i_type(opc_op_imm, 3'b001, 9, 1, 4));
        expect_retire(36, 32'h23456780);
        prog.push_back(r_type(7'h20, 3'b000, 10, 1, 3));
        expect_retire(40, 32'h1234567d);
        prog.push_back(r_type(7'h00, 3'b110, 11, 1, 4));
        expect_retire(44, 32'h12345679);
        prog.push_back(r_type(7'h00, 3'b111, 14, 1, 11));
        expect_retire(48, 32'h12345678);
        prog.push_back(r_type(7'h00, 3'b000, 7, 1, 3));
        expect_retire(52, 32'h12345673);
        prog.push_back(i_type(opc_op_imm, 3'b000, 0, 1, 1));
        expect_retire(56, 32'h0);
        // reads x0 back, so x0 must still be zero
        prog.push_back(i_type(opc_op_imm, 3'b000, 12, 0, 'h200));
        expect_retire(60, 32'h200);
        prog.push_back(s_type(3'b010, 12, 1, 0));           // sw x1, 0(x12)
        expect_store(32'h200, 32'h12345678, 4'b1111);
        expect_retire(64, 32'h0);
        prog.push_back(s_type(3'b000, 12, 3, 5));           // sb x3, 5(x12)
        expect_store(32'h204, 32'h0000fb00, 4'b0010);
        expect_retire(68, 32'h0);
        prog.push_back(s_type(3'b001, 12, 6, 10));          // sh x6, 10(x12)
        expect_store(32'h208, 32'ha9870000, 4'b1100);
        expect_retire(72, 32'h0);
        prog.push_back(i_type(opc_load, 3'b000, 13, 12, 5));
        expect_retire(76, 32'hfffffffb);
        prog.push_back(i_type(opc_load, 3'b100, 14, 12, 5));
        expect_retire(80, 32'h000000fb);
        prog.push_back(i_type(opc_load, 3'b001, 15, 12, 10));
        expect_retire(84, 32'hffffa987);
        prog.push_back(i_type(opc_load, 3'b101, 15, 12, 10));
        expect_retire(88, 32'h0000a987);
        prog.push_back(i_type(opc_load, 3'b010, 13, 12, 0));
        expect_retire(92, 32'h12345678);
        prog.push_back(b_type(3'b000, 4, 5, 8));  // not taken
        expect_retire(96, 32'h0);
        prog.push_back(b_type(3'b001, 4, 5, 8));  // taken
        expect_retire(100, 32'h0);
        prog.push_back(wrong_path);
        prog.push_back(j_type(5, 8));
        expect_retire(108, 32'd112);
        prog.push_back(wrong_path);
        prog.push_back(i_type(opc_jalr, 3'b000, 6, 5, 12));
        expect_retire(116, 32'd120);
        prog.push_back(wrong_path);
        prog.push_back(i_type(opc_system, 3'b000, 0, 0, 1));  // ebreak
    endtask

    task automatic build_illegal_program();
        prog.push_back(i_type(opc_op_imm, 3'b000, 1, 0, 7));
        expect_retire(0, 32'd7);
        prog.push_back(32'h0000007f);  // opcode 1111111 is not defined
    endtask

    task automatic run_program(input logic expect_halt);
        int         limit;
        int         cycles;
        int         next;
        logic [7:0] idx;
        limit = 40 * prog.size() + 100;
        cycles = 0;
        next = 0;
        for (int i = 0; i < 256; i++) begin
            idx = 8'(i);
            mem[idx] = {8'hc3, idx, ~idx, idx ^ 8'h5a};
        end
        foreach (prog[i]) begin
            idx = reset_pc[9:2] + 8'(i);
            mem[idx] = prog[i];
        end
        @(posedge clock);
        #1 rst = 1'b1;
        repeat (10) @(posedge clock);
        #1 rst = 1'b0;
        check_true(!mem_valid && !retire && !halt && !illegal, "outputs not idle after reset");
        while (!(halt || illegal)) begin
            @(negedge clock);
            cycles++;
            check_true(cycles <= limit, "timeout, the core never stopped");
            if (retire) begin
                check_true(next < ev_store.size() && !ev_store[next], "unexpected retire");
                check_value("retire_pc", ev_addr[next], retire_pc);
                check_value("retire_rd_value", ev_data[next], retire_rd_value);
                next++;
            end
            if (mem_valid && mem_ready) begin
                check_true(mem_addr[1:0] == 2'b00, "memory address not word-aligned");
                if (mem_write) begin
                    check_true(next < ev_store.size() && ev_store[next], "unexpected store");
                    check_value("mem_addr", ev_addr[next], mem_addr);
                    check_value("mem_strb", {28'h0, ev_strb[next]}, {28'h0, mem_strb});
                    check_value("mem_wdata", ev_data[next] & byte_mask(ev_strb[next]),
                                mem_wdata & byte_mask(mem_strb));
                    mem[mem_addr[9:2]] = (mem[mem_addr[9:2]] & ~byte_mask(mem_strb)) |
                                         (mem_wdata & byte_mask(mem_strb));
                    next++;
                end
            end
        end
        check_value("halt", {31'h0, expect_halt}, {31'h0, halt});
        check_value("illegal", {31'h0, !expect_halt}, {31'h0, illegal});
        check_true(next == ev_store.size(), "core stopped before all expected events");
        repeat (20) begin
            @(negedge clock);
            check_true(!retire && !mem_valid, "activity after the core stopped");
        end
    endtask

    initial begin
        build_main_program();
        run_program(1'b1);
        prog.delete();
        ev_store.delete();
        ev_addr.delete();
        ev_data.delete();
        ev_strb.delete();
        build_illegal_program();
        run_program(1'b0);
        $display("STATUS: PASS");
        $finish;
    end

endmodule

// ==== core_top.f ====
src/core_pkg.sv
src/fetch_unit.sv
src/decoder.sv
src/reg_file.sv
src/execute_unit.sv
src/load_store_unit.sv
src/core_top.sv
testbench/tb_core_top.sv

// ==== Makefile ====
TOP = tb_core_top

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert --top-module $(TOP) -f core_top.f

run: build
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx 'STATUS: PASS'

lint:
	verilator --lint-only -Wall --timing --assert --top-module $(TOP) -f core_top.f

clean:
	rm -rf obj_dir
